// ==== compile.f ====
src/com_pkg.sv
src/led_pkg.sv
src/ms_tick_gen.sv
src/com_frame_mon.sv
src/com_led_ctl.sv
src/com_ind_top.sv
testbench/tb_com_ind.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps --top-module tb_com_ind \
    -f compile.f -Mdir obj_dir > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vtb_com_ind > sim.log 2>&1

grep -qx "TB PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== src/com_frame_mon.sv ====
/*
 * Per-slot frame monitor. Checks frame length and additive checksum
 * and emits one-cycle good-end or error strobes, one cycle after the byte.
 */

`default_nettype none

module com_frame_mon
    import com_pkg::*;
#(
    parameter int MAX_FRAME_LEN = 64
) (
    input  logic      clk_sys,
    input  logic      rst_sys_n,
    input  com_byte_t rx_byte,
    output com_trig_t com_trig
);

    // Length counter holds up to one above the limit
    localparam int LEN_W = $clog2(MAX_FRAME_LEN + 2);
    localparam logic [LEN_W-1:0] LEN_MAX = LEN_W'(MAX_FRAME_LEN);
    localparam logic [LEN_W-1:0] LEN_SAT = LEN_W'(MAX_FRAME_LEN + 1);

    mon_state_e       state, state_nxt;
    logic [7:0]       sum, sum_nxt;
    logic [LEN_W-1:0] len, len_nxt;
    logic [7:0]       sum_add;
    logic [LEN_W-1:0] len_inc;
    com_trig_t        trig_nxt;

    // Running sum and saturating length including the current byte
    assign sum_add = sum + rx_byte.data;
    assign len_inc = (len == LEN_SAT) ? len : len + 1'b1;

    // ----------------------------------------------------------------------
    // Frame rules
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        sum_nxt   = sum;
        len_nxt   = len;
        trig_nxt  = '0;
        if (rx_byte.valid) begin
            if (rx_byte.sop) begin
                // Open frame gets abandoned
                trig_nxt.err = (state == MON_FRAME);
                if (rx_byte.eop) begin
                    // One-byte frame, sum is the byte itself
                    state_nxt = MON_IDLE;
                    if (rx_byte.data == 8'd0) begin
                        trig_nxt.eop = 1'b1;
                    end else begin
                        trig_nxt.err = 1'b1;
                    end
                end else begin
                    state_nxt = MON_FRAME;
                    sum_nxt   = rx_byte.data;
                    len_nxt   = LEN_W'(1);
                end
            end else if (state == MON_IDLE) begin
                // Stray byte outside any frame
                trig_nxt.err = 1'b1;
            end else if (rx_byte.eop) begin
                state_nxt = MON_IDLE;
                // Good only with zero sum and legal length
                if ((sum_add == 8'd0) && (len_inc <= LEN_MAX)) begin
                    trig_nxt.eop = 1'b1;
                end else begin
                    trig_nxt.err = 1'b1;
                end
            end else begin
                sum_nxt = sum_add;
                len_nxt = len_inc;
            end
        end
    end

    // State, accumulators and registered strobes
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state    <= MON_IDLE;
            sum      <= '0;
            len      <= '0;
            com_trig <= '0;
        end else begin
            state    <= state_nxt;
            sum      <= sum_nxt;
            len      <= len_nxt;
            com_trig <= trig_nxt;
        end
    end

endmodule : com_frame_mon

`default_nettype wire

// ==== src/com_ind_top.sv ====
/*
 * Communication status indicator top. One shared millisecond tick,
 * then per slot a frame monitor feeding an LED controller.
 */

`default_nettype none

module com_ind_top
    import com_pkg::*;
    import led_pkg::*;
#(
    parameter int NUM_SLOTS     = 4,
    parameter int CLK_PER_MS    = 100000,
    parameter int MAX_FRAME_LEN = 64
) (
    input  logic                           clk_sys,
    input  logic                           rst_sys_n,
    input  logic                           cfg_en,
    input  logic      [NUM_SLOTS-1:0]      slot_en,
    input  com_byte_t [NUM_SLOTS-1:0]      rx_byte,
    output com_led_t  [NUM_SLOTS-1:0]      com_led
);

    logic                        ms_tick;
    com_trig_t [NUM_SLOTS-1:0]   com_trig;

    // Millisecond enable shared by every slot
    ms_tick_gen #(
        .CLK_PER_MS (CLK_PER_MS)
    ) u_ms_tick_gen (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .ms_tick   (ms_tick)
    );

    // ----------------------------------------------------------------------
    // Per-slot monitor and LED controller
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : gen_slot
        com_frame_mon #(
            .MAX_FRAME_LEN (MAX_FRAME_LEN)
        ) u_frame_mon (
            .clk_sys   (clk_sys),
            .rst_sys_n (rst_sys_n),
            .rx_byte   (rx_byte[i]),
            .com_trig  (com_trig[i])
        );

        com_led_ctl u_led_ctl (
            .clk_sys   (clk_sys),
            .rst_sys_n (rst_sys_n),
            .ms_tick   (ms_tick),
            .cfg_en    (cfg_en),
            .slot_en   (slot_en[i]),
            .com_trig  (com_trig[i]),
            .com_led   (com_led[i])
        );
    end

endmodule : com_ind_top

`default_nettype wire

// ==== src/com_led_ctl.sv ====
/*
 * Per-slot LED controller. Green toggles per millisecond with activity,
 * red pulses one cycle, three stages after an error strobe.
 */

`default_nettype none

module com_led_ctl
    import com_pkg::*;
    import led_pkg::*;
(
    input  logic      clk_sys,
    input  logic      rst_sys_n,
    input  logic      ms_tick,
    input  logic      cfg_en,
    input  logic      slot_en,
    input  com_trig_t com_trig,
    output com_led_t  com_led
);

    logic [COM_CNT_W-1:0] com_cnt;
    logic [2:0]           err_dly;
    logic                 led_en;
    logic                 led_act;
    logic                 led_err;

    // Both enables needed to light anything
    assign led_en = slot_en & cfg_en;

    // ----------------------------------------------------------------------
    // Good frames since last tick
    // ----------------------------------------------------------------------
    // Tick wins over a same-cycle eop
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            com_cnt <= '0;
        end else if (ms_tick) begin
            com_cnt <= '0;
        end else if (com_trig.eop && (com_cnt != COM_CNT_MAX)) begin
            com_cnt <= com_cnt + 1'b1;
        end
    end

    // Green LED toggles while active, dark on an idle millisecond
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            led_act <= 1'b0;
        end else if (!led_en) begin
            led_act <= 1'b0;
        end else if (ms_tick) begin
            led_act <= (com_cnt != '0) ? ~led_act : 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Error delay line and red LED
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            err_dly <= '0;
            led_err <= 1'b0;
        end else begin
            err_dly <= {err_dly[1:0], com_trig.err};
            led_err <= err_dly[2] & led_en;
        end
    end

    assign com_led = '{err: led_err, act: led_act};

endmodule : com_led_ctl

`default_nettype wire

// ==== src/com_pkg.sv ====
/*
 * Link-side types shared by the frame monitor, the LED controller and the top.
 * Modules pull these in with a wildcard import in their header.
 */

`default_nettype none

package com_pkg;

    // ----------------------------------------------------------------------
    // Received byte, one per slot per cycle
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic       valid;  // Byte present this cycle
        logic       sop;    // First byte of a frame
        logic       eop;    // Last byte of a frame
        logic [7:0] data;
    } com_byte_t;

    // Monitor strobes, eop kept as the upper bit
    typedef struct packed {
        logic eop;          // Good frame ended
        logic err;          // Frame error
    } com_trig_t;

    // Frame monitor FSM
    typedef enum logic [0:0] {
        MON_IDLE  = 1'b0,
        MON_FRAME = 1'b1
    } mon_state_e;

endpackage : com_pkg

`default_nettype wire

// ==== src/led_pkg.sv ====
/*
 * Indicator-side types and constants for the per-slot LED controller.
 * Imported by the LED controller and the top level.
 */

`default_nettype none

package led_pkg;

    // ----------------------------------------------------------------------
    // LED pair driven to the front panel
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic err;          // Red LED
        logic act;          // Green LED
    } com_led_t;

    // Activity counter width
    localparam int COM_CNT_W = 5;

    // Saturation value of the activity counter
    localparam logic [COM_CNT_W-1:0] COM_CNT_MAX = '1;

endpackage : led_pkg

`default_nettype wire

// ==== src/ms_tick_gen.sv ====
/*
 * Millisecond enable generator shared by all slots.
 * Pulses ms_tick for one clk_sys cycle every CLK_PER_MS cycles.
 */

`default_nettype none

module ms_tick_gen #(
    parameter int CLK_PER_MS = 100000
) (
    input  logic clk_sys,
    input  logic rst_sys_n,
    output logic ms_tick
);

    // Down counter width, at least one bit
    localparam int CNT_W = (CLK_PER_MS > 1) ? $clog2(CLK_PER_MS) : 1;
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(CLK_PER_MS - 1);

    logic [CNT_W-1:0] ms_cnt;

    // Count down, reload at zero
    // Tick registered so the first pulse lands CLK_PER_MS cycles after reset
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            ms_cnt  <= CNT_LOAD;
            ms_tick <= 1'b0;
        end else begin
            ms_tick <= (ms_cnt == '0);
            if (ms_cnt == '0) begin
                ms_cnt <= CNT_LOAD;
            end else begin
                ms_cnt <= ms_cnt - 1'b1;
            end
        end
    end

endmodule : ms_tick_gen

`default_nettype wire

// ==== testbench/tb_com_ind.sv ====
/*
 * Self-checking testbench for the communication status indicator.
 * Sends good and broken frames per slot, models LEDs from the frame rules
 * and compares them every cycle with concurrent assertions.
 */

`default_nettype none

module tb_com_ind
    import com_pkg::*;
    import led_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SLOTS     = 4;
    localparam int CLK_PER_MS    = 64;
    localparam int MAX_FRAME_LEN = 16;
    localparam logic [COM_CNT_W-1:0] CNT_MAX = '1;

    logic                        clk_sys;
    logic                        rst_sys_n;
    logic                        cfg_en;
    logic      [NUM_SLOTS-1:0]   slot_en;
    com_byte_t [NUM_SLOTS-1:0]   rx_byte;
    com_led_t  [NUM_SLOTS-1:0]   com_led;

    // Reference model state
    int                   ms_cnt;
    logic                 tick_q;
    logic [NUM_SLOTS-1:0] m_open;
    logic [7:0]           m_sum    [NUM_SLOTS];
    int                   m_len    [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] eop_q;
    logic [COM_CNT_W-1:0] act_cnt  [NUM_SLOTS];
    logic [3:0]           err_pipe [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] exp_act;
    logic [NUM_SLOTS-1:0] exp_err;

    logic [31:0] rng;
    string       test_name;
    int          n_mismatch;
    int          n_fail;

    com_ind_top #(
        .NUM_SLOTS     (NUM_SLOTS),
        .CLK_PER_MS    (CLK_PER_MS),
        .MAX_FRAME_LEN (MAX_FRAME_LEN)
    ) uut (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .cfg_en    (cfg_en),
        .slot_en   (slot_en),
        .rx_byte   (rx_byte),
        .com_led   (com_led)
    );

    // 20 ns clock
    always #10 clk_sys = ~clk_sys;

    // ----------------------------------------------------------------------
    // Reference model, built from the frame and LED timing rules
    // ----------------------------------------------------------------------
    always @(posedge clk_sys or negedge rst_sys_n) begin : ref_model
        logic       good;
        logic       bad;
        logic       open;
        logic       en;
        logic [7:0] sum;
        int         len;
        if (!rst_sys_n) begin
            ms_cnt  <= 0;
            tick_q  <= 1'b0;
            m_open  <= '0;
            eop_q   <= '0;
            exp_act <= '0;
            exp_err <= '0;
            for (int s = 0; s < NUM_SLOTS; s++) begin
                m_sum[s]    <= 8'd0;
                m_len[s]    <= 0;
                act_cnt[s]  <= '0;
                err_pipe[s] <= 4'd0;
            end
        end else begin
            // Tick pulse lands in the CLK_PER_MS-th cycle after reset
            if (ms_cnt == CLK_PER_MS - 1) begin
                ms_cnt <= 0;
                tick_q <= 1'b1;
            end else begin
                ms_cnt <= ms_cnt + 1;
                tick_q <= 1'b0;
            end
            for (int s = 0; s < NUM_SLOTS; s++) begin
                good = 1'b0;
                bad  = 1'b0;
                open = m_open[s];
                sum  = m_sum[s];
                len  = m_len[s];
                if (rx_byte[s].valid) begin
                    // sop abandons an open frame and restarts
                    if (rx_byte[s].sop) begin
                        bad  = open;
                        open = 1'b1;
                        sum  = 8'd0;
                        len  = 0;
                    end else if (!open) begin
                        bad = 1'b1;
                    end
                    if (open) begin
                        sum = sum + rx_byte[s].data;
                        len = len + 1;
                        if (rx_byte[s].eop) begin
                            open = 1'b0;
                            if ((sum == 8'd0) && (len <= MAX_FRAME_LEN)) begin
                                good = 1'b1;
                            end else begin
                                bad = 1'b1;
                            end
                        end
                    end
                end
                m_open[s] <= open;
                m_sum[s]  <= sum;
                m_len[s]  <= len;
                en        = slot_en[s] & cfg_en;
                // Strobe one cycle after the byte, then counted
                eop_q[s]  <= good;
                if (tick_q) begin
                    act_cnt[s] <= '0;
                end else if (eop_q[s] && (act_cnt[s] != CNT_MAX)) begin
                    act_cnt[s] <= act_cnt[s] + 1'b1;
                end
                if (!en) begin
                    exp_act[s] <= 1'b0;
                end else if (tick_q) begin
                    exp_act[s] <= (act_cnt[s] != '0) ? ~exp_act[s] : 1'b0;
                end
                // Red five cycles after the offending byte
                err_pipe[s] <= {err_pipe[s][2:0], bad};
                exp_err[s]  <= err_pipe[s][3] & en;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Checks, sampled on the falling edge where outputs are settled
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : gen_chk
        assert property (@(negedge clk_sys) disable iff (!rst_sys_n)
            com_led[i].act == exp_act[i])
        else begin
            n_mismatch = n_mismatch + 1;
            $display("Mismatch %s slot %0d green: expected %0b actual %0b",
                     test_name, i, exp_act[i], com_led[i].act);
        end

        assert property (@(negedge clk_sys) disable iff (!rst_sys_n)
            com_led[i].err == exp_err[i])
        else begin
            n_mismatch = n_mismatch + 1;
            $display("Mismatch %s slot %0d red: expected %0b actual %0b",
                     test_name, i, exp_err[i], com_led[i].err);
        end
    end

    // LEDs dark while reset is held
    assert property (@(negedge clk_sys) rst_sys_n || (com_led == '0))
    else begin
        n_fail = n_fail + 1;
        $display("LEDs not dark during reset");
    end

    assert property (@(negedge clk_sys) disable iff (!rst_sys_n) uut.ms_tick == tick_q)
    else begin
        n_mismatch = n_mismatch + 1;
        $display("Mismatch %s ms_tick: expected %0b actual %0b",
                 test_name, tick_q, uut.ms_tick);
    end

    // Slot 0 carries the burst, so its count must stop at the top
    assert property (@(negedge clk_sys) disable iff (!rst_sys_n)
        uut.gen_slot[0].u_led_ctl.com_cnt == act_cnt[0])
    else begin
        n_mismatch = n_mismatch + 1;
        $display("Mismatch %s slot 0 activity count: expected %0d actual %0d",
                 test_name, act_cnt[0], uut.gen_slot[0].u_led_ctl.com_cnt);
    end

    // Slot 1 carries the error cases
    assert property (@(negedge clk_sys) disable iff (!rst_sys_n)
        (uut.gen_slot[1].u_frame_mon.state == MON_FRAME) == m_open[1])
    else begin
        n_mismatch = n_mismatch + 1;
        $display("Mismatch %s slot 1 frame open: expected %0b actual %0b", test_name,
                 m_open[1], uut.gen_slot[1].u_frame_mon.state == MON_FRAME);
    end

    // ----------------------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Frame length 2..9
    function automatic int rand_len();
        rng = xorshift32(rng);
        return 2 + int'(rng[2:0]);
    endfunction

    task automatic send_byte(input int slot, input logic sop, input logic eop,
                             input logic [7:0] data);
        @(negedge clk_sys);
        rx_byte[slot] = '{valid: 1'b1, sop: sop, eop: eop, data: data};
    endtask

    task automatic send_idle(input int slot);
        @(negedge clk_sys);
        rx_byte[slot] = '0;
    endtask

    // Random payload, last byte zeroes the sum unless bad
    task automatic send_frame(input int slot, input int len, input logic bad);
        logic [7:0] sum;
        logic [7:0] data;
        sum = 8'd0;
        for (int k = 0; k < len; k++) begin
            if (k == len - 1) begin
                data = 8'd0 - sum;
                if (bad) begin
                    data = data + 8'd1;
                end
            end else begin
                rng  = xorshift32(rng);
                data = rng[7:0];
            end
            sum = sum + data;
            send_byte(slot, k == 0, k == len - 1, data);
        end
        send_idle(slot);
    endtask

    // Returns on the falling edge just before a tick edge
    task automatic wait_tick();
        int k;
        for (k = 0; k < CLK_PER_MS + 4; k++) begin
            @(negedge clk_sys);
            if (tick_q) begin
                break;
            end
        end
        if (k == CLK_PER_MS + 4) begin
            n_fail = n_fail + 1;
            $display("No millisecond tick within %0d cycles in %s", CLK_PER_MS + 4, test_name);
        end
    endtask

    task automatic wait_red(input int slot);
        int k;
        for (k = 0; k < 10; k++) begin
            if (com_led[slot].err) begin
                break;
            end
            @(negedge clk_sys);
        end
        if (k == 10) begin
            n_fail = n_fail + 1;
            $display("Red LED on slot %0d never lit in %s", slot, test_name);
        end
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        clk_sys    = 1'b0;
        rst_sys_n  = 1'b0;
        cfg_en     = 1'b1;
        slot_en    = '1;
        rx_byte    = '0;
        rng        = 32'd17191;
        n_mismatch = 0;
        n_fail     = 0;
        test_name  = "reset";
        repeat (16) @(negedge clk_sys);
        rst_sys_n = 1'b1;
        wait_tick();

        // Toggle, toggle, toggle, then an idle millisecond clears
        test_name = "good_act";
        for (int m = 0; m < 3; m++) begin
            send_frame(0, rand_len(), 1'b0);
            send_frame(0, MAX_FRAME_LEN, 1'b0);
            wait_tick();
        end
        wait_tick();

        test_name = "err_sum";
        send_frame(1, 5, 1'b1);
        wait_red(1);
        test_name = "err_len";
        send_frame(1, MAX_FRAME_LEN + 1, 1'b0);
        wait_red(1);
        test_name = "err_stray";
        send_byte(1, 1'b0, 1'b0, 8'h5a);
        send_idle(1);
        wait_red(1);
        wait_tick();
        // Restart inside a frame, new frame still good
        test_name = "err_sop";
        send_byte(1, 1'b1, 1'b0, 8'h33);
        send_byte(1, 1'b0, 1'b0, 8'h44);
        send_frame(1, 4, 1'b0);
        wait_red(1);
        wait_tick();

        test_name = "slot_en";
        send_frame(2, 4, 1'b0);
        wait_tick();
        // Drop the enable mid-millisecond while green is lit
        @(negedge clk_sys);
        slot_en[2] = 1'b0;
        send_frame(2, 4, 1'b0);
        send_frame(0, 3, 1'b0);
        send_frame(2, 3, 1'b1);
        wait_tick();
        slot_en[2] = 1'b1;

        test_name = "cfg_en";
        send_frame(3, 5, 1'b0);
        wait_tick();
        @(negedge clk_sys);
        cfg_en = 1'b0;
        send_frame(3, 5, 1'b0);
        send_frame(3, 2, 1'b1);
        wait_tick();
        cfg_en = 1'b1;

        // 40 one-byte frames inside one millisecond
        test_name = "saturate";
        wait_tick();
        for (int k = 0; k < 40; k++) begin
            send_byte(0, 1'b1, 1'b1, 8'h00);
        end
        send_idle(0);
        wait_tick();
        wait_tick();
        repeat (4) @(negedge clk_sys);

        $display("Checks done: %0d mismatches, %0d other failures", n_mismatch, n_fail);
        if ((n_mismatch == 0) && (n_fail == 0)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_com_ind

`default_nettype wire
